// File: rtl/p2p_params.svh
`ifndef P2P_PARAMS_SVH
`define P2P_PARAMS_SVH

// **********************************************************************
// channel widths
// **********************************************************************
`define P2P_DATA_W   64                 // cfg data beat
`define P2P_HEAD_W   128                // cfg request head
`define P2P_UHEAD_W  64                 // forward (upper) head

// **********************************************************************
// table entry fields and geometry
// **********************************************************************
`define DEV_NUM_W    8                  // device number
`define DEV_TYPE_W   4                  // device type
`define BAR_ADDR_W   50                 // bar payload base, addr[63:14]
`define TAB_AW       4                  // 16 entries

// table window in cfg space, bits 19:TAB_AW+4 compared
`define TAB_WIN_BASE 32'h000A_0000

`endif

// File: rtl/p2p_fwd_pkg.sv
`default_nettype none

`include "p2p_params.svh"

package p2p_fwd_pkg;

    // forward head, only meaningful on the first beat of a packet
    typedef struct packed {
        logic [`P2P_UHEAD_W-49:0] rsvd_hi;  // 63:48
        logic [`DEV_NUM_W-1:0]    dst_dev;  // 47:40, table index source
        logic [`DEV_NUM_W-1:0]    src_dev;  // 39:32
        logic [15:0]              rsvd_lo;  // 31:16
        logic [15:0]              byte_len; // 15:0
    } fwd_head_t;

    // one stored table word
    typedef struct packed {
        logic [`BAR_ADDR_W-1:0] bar_base;   // low 14 addr bits implied zero
        logic [`DEV_TYPE_W-1:0] dev_type;
        logic [`DEV_NUM_W-1:0]  dev_num;
    } tab_entry_t;

    // result handed to the dst processor
    typedef struct packed {
        logic                   hit;        // entry was written before
        logic [`BAR_ADDR_W-1:0] bar_base;
        logic [`DEV_TYPE_W-1:0] dev_type;
        logic [`DEV_NUM_W-1:0]  dev_num;
    } route_t;

endpackage

`default_nettype wire

// File: rtl/p2p_cfg_pkg.sv
`default_nettype none

`include "p2p_params.svh"

package p2p_cfg_pkg;

    // cfg request head
    // | 127   | 126:64 | 63:32 | 31:13 | 12:0     |
    // | is_wr | rsvd   | addr  | rsvd  | byte_len |
    typedef struct packed {
        logic                    is_wr;
        logic [`P2P_HEAD_W-66:0] rsvd_hi;   // 63 bits
        logic [31:0]             addr;      // bar0 offset
        logic [18:0]             rsvd_lo;
        logic [12:0]             byte_len;
    } cfg_head_t;

    // decoded table write
    typedef struct packed {
        logic                    en;        // single-cycle strobe
        logic [`TAB_AW-1:0]      idx;
        p2p_fwd_pkg::tab_entry_t entry;
    } tab_wr_t;

endpackage

`default_nettype wire

// File: rtl/cfg_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "p2p_params.svh"

// turns a taken cfg beat into a table write strobe, purely combinational
module cfg_decode (
    input  logic                   cfg_take,      // valid & ready this cycle
    input  p2p_cfg_pkg::cfg_head_t cfg_req_head,
    input  logic [`P2P_DATA_W-1:0] cfg_req_data,
    output p2p_cfg_pkg::tab_wr_t   tab_wr
);

    import p2p_fwd_pkg::*;

    localparam logic [31:0] WIN_BASE = `TAB_WIN_BASE;
    localparam int          IDX_LO   = 4;               // 16-byte entry stride
    localparam int          WIN_LO   = `TAB_AW + IDX_LO;

    logic       in_win;
    logic       is_wr;
    tab_entry_t entry;

    // ******************************************************************
    // address decode
    // ******************************************************************
    assign is_wr  = cfg_req_head.is_wr;
    assign in_win = (cfg_req_head.addr[19:WIN_LO] == WIN_BASE[19:WIN_LO]);

    // ******************************************************************
    // data word unpack
    // ******************************************************************
    // | 63:14    | 13:12 | 11:8     | 7:0     |
    // | bar_base | rsvd  | dev_type | dev_num |
    always_comb begin
        entry.dev_num  = cfg_req_data[`DEV_NUM_W-1:0];
        entry.dev_type = cfg_req_data[`DEV_TYPE_W+7:8];
        entry.bar_base = cfg_req_data[`P2P_DATA_W-1:`P2P_DATA_W-`BAR_ADDR_W];
    end

    // ******************************************************************
    // write strobe
    // ******************************************************************
    always_comb begin
        tab_wr.en    = cfg_take & is_wr & in_win;              // reads dropped here
        tab_wr.idx   = cfg_req_head.addr[WIN_LO-1:IDX_LO];     // entry index
        tab_wr.entry = entry;
    end

endmodule

`default_nettype wire

// File: rtl/dev_table_sram.sv
`timescale 1ns/1ps
`default_nettype none

// 1w1r table store, registered read, valid bit per entry
module dev_table_sram #(
    parameter type entry_t = p2p_fwd_pkg::tab_entry_t,
    parameter int  AW      = 4                          // depth = 2**AW
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_idx,
    input  entry_t        wr_entry,
    input  logic          rd_en,
    input  logic [AW-1:0] rd_idx,
    output logic          rd_hit,      // entry was ever written
    output entry_t        rd_entry
);

    entry_t            mem [2**AW];
    logic [2**AW-1:0]  vld;

    // storage array, no reset on payload
    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_idx] <= wr_entry;
        if (rd_en) rd_entry    <= mem[rd_idx];   // old data on same-index collision
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld    <= '0;                        // table empty after reset
            rd_hit <= 1'b0;
        end else begin
            if (wr_en) vld[wr_idx] <= 1'b1;
            if (rd_en) rd_hit      <= vld[rd_idx];  // held between reads
        end
    end

endmodule

`default_nettype wire

// File: rtl/fwd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// sop tracking on the monitored forward stream, lookup issue,
// cfg arbitration and the route valid flag
module fwd_ctrl (
    input  logic clk,
    input  logic rst_n,

    // cfg channel handshake
    input  logic cfg_req_valid,
    output logic cfg_req_ready,
    output logic cfg_take,          // cfg beat accepted this cycle

    // forward stream, observed only
    input  logic upper_valid,
    input  logic upper_last,
    input  logic upper_ready,       // owned by downstream consumer
    output logic lookup,            // table read strobe

    // result handshake
    input  logic is_ready,
    output logic route_valid
);

    logic beat;                     // a forward beat moves
    logic sop;                      // next beat starts a packet

    assign beat = upper_valid & upper_ready;

    // ******************************************************************
    // start of packet flag
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sop <= 1'b1;            // first beat after reset is a head
        end else if (beat & upper_last) begin
            sop <= 1'b1;
        end else if (beat) begin
            sop <= 1'b0;            // mid-packet from here
        end
    end

    assign lookup = sop & beat;     // head beat handshake

    // ******************************************************************
    // cfg arbitration
    // ******************************************************************
    // lookup has priority so a write never collides with a read
    assign cfg_req_ready = ~lookup;
    assign cfg_take      = cfg_req_valid & cfg_req_ready;

    // ******************************************************************
    // route valid, one cycle after lookup
    // ******************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            route_valid <= 1'b0;
        end else if (lookup) begin
            route_valid <= 1'b1;    // new result, overwrites any unconsumed one
        end else if (is_ready) begin
            route_valid <= 1'b0;    // consumed
        end
    end

endmodule

`default_nettype wire

// File: rtl/dev2addr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "p2p_params.svh"

// device number -> bar address lookup stage
module dev2addr_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // ******************************************************************
    // cfg channel in
    // ******************************************************************
    input  logic                   cfg_req_valid,
    input  logic                   cfg_req_last,    // always set, single-beat cfg
    input  logic [`P2P_DATA_W-1:0] cfg_req_data,
    input  p2p_cfg_pkg::cfg_head_t cfg_req_head,
    output logic                   cfg_req_ready,

    // ******************************************************************
    // forward channel, monitored
    // ******************************************************************
    input  logic                   upper_valid,
    input  logic                   upper_last,
    input  p2p_fwd_pkg::fwd_head_t upper_head,
    input  logic                   upper_ready,

    // ******************************************************************
    // route result out
    // ******************************************************************
    output logic                   route_valid,
    output p2p_fwd_pkg::route_t    route,
    input  logic                   is_ready
);

    import p2p_cfg_pkg::*;
    import p2p_fwd_pkg::*;

    logic               cfg_take;
    logic               lookup;
    logic [`TAB_AW-1:0] rd_idx;
    logic               rd_hit;
    tab_wr_t            tab_wr;
    tab_entry_t         rd_entry;

    assign rd_idx = upper_head.dst_dev[`TAB_AW-1:0];   // low bits index the table

    fwd_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_req_valid (cfg_req_valid),
        .cfg_req_ready (cfg_req_ready),
        .cfg_take      (cfg_take),
        .upper_valid   (upper_valid),
        .upper_last    (upper_last),
        .upper_ready   (upper_ready),
        .lookup        (lookup),
        .is_ready      (is_ready),
        .route_valid   (route_valid)
    );

    cfg_decode u_cfg (
        .cfg_take     (cfg_take),
        .cfg_req_head (cfg_req_head),
        .cfg_req_data (cfg_req_data),
        .tab_wr       (tab_wr)
    );

    dev_table_sram #(
        .entry_t (tab_entry_t),
        .AW      (`TAB_AW)
    ) u_tab (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (tab_wr.en),
        .wr_idx   (tab_wr.idx),
        .wr_entry (tab_wr.entry),
        .rd_en    (lookup),
        .rd_idx   (rd_idx),
        .rd_hit   (rd_hit),
        .rd_entry (rd_entry)
    );

    // result pack, valid qualified by route_valid
    assign route = '{hit:      rd_hit,
                     bar_base: rd_entry.bar_base,
                     dev_type: rd_entry.dev_type,
                     dev_num:  rd_entry.dev_num};

endmodule

`default_nettype wire

// File: tests/tb_dev2addr.sv
`timescale 1ns/1ps
`default_nettype none

`include "p2p_params.svh"

module tb_dev2addr;

    import p2p_cfg_pkg::*;
    import p2p_fwd_pkg::*;

    localparam int          MAX_CYCLES = 2000;         // tests take ~600, rest is margin
    localparam int          DEPTH      = 1 << `TAB_AW;
    localparam logic [31:0] WIN        = `TAB_WIN_BASE;

    logic                   clk;
    logic                   rst_n;
    logic                   cfg_req_valid;
    logic                   cfg_req_last;
    logic [`P2P_DATA_W-1:0] cfg_req_data;
    cfg_head_t              cfg_req_head;
    logic                   cfg_req_ready;
    logic                   upper_valid;
    logic                   upper_last;
    fwd_head_t              upper_head;
    logic                   upper_ready;
    logic                   route_valid;
    route_t                 route;
    logic                   is_ready;

    tab_entry_t       model_mem [DEPTH];               // reference table
    logic [DEPTH-1:0] model_vld;
    int               seed    = 96;
    int               cycles  = 0;
    int               results = 0;                     // consumed route results

    dev2addr_top dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_req_valid (cfg_req_valid),
        .cfg_req_last  (cfg_req_last),
        .cfg_req_data  (cfg_req_data),
        .cfg_req_head  (cfg_req_head),
        .cfg_req_ready (cfg_req_ready),
        .upper_valid   (upper_valid),
        .upper_last    (upper_last),
        .upper_head    (upper_head),
        .upper_ready   (upper_ready),
        .route_valid   (route_valid),
        .route         (route),
        .is_ready      (is_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                        // 100 ns period
    end

    // cycle limit, plus a count of results taken by downstream
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (route_valid && is_ready) results = results + 1;   // pre-edge values
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1, "simulation timeout");
        end
    end

    // **********************************************************************
    // helpers
    // **********************************************************************
    task automatic check(input string name, input logic [127:0] act, input logic [127:0] exp);
        if (act !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, act, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic tab_entry_t rand_entry();
        tab_entry_t  e;
        logic [63:0] r;
        r          = {$random(seed), $random(seed)};
        e.bar_base = r[63:14];
        e.dev_type = r[11:8];
        e.dev_num  = r[7:0];
        return e;
    endfunction

    function automatic logic [31:0] entry_addr(input logic [`TAB_AW-1:0] idx);
        return WIN | (32'(idx) << 4);                  // 16-byte stride per entry
    endfunction

    function automatic bit in_window(input logic [31:0] addr);
        return addr[19:`TAB_AW+4] == WIN[19:`TAB_AW+4];
    endfunction

    // table update rule, only in-window writes land
    task automatic model_update(input logic is_wr, input logic [31:0] addr, input tab_entry_t e);
        if (is_wr && in_window(addr)) begin
            model_mem[addr[`TAB_AW+3:4]] = e;
            model_vld[addr[`TAB_AW+3:4]] = 1'b1;
        end
    endtask

    task automatic drive_cfg(input logic is_wr, input logic [31:0] addr, input tab_entry_t e);
        cfg_head_t h;
        h          = '0;
        h.is_wr    = is_wr;
        h.addr     = addr;
        h.byte_len = 13'd8;
        cfg_req_valid <= 1'b1;
        cfg_req_last  <= 1'b1;                         // single-beat cfg packet
        cfg_req_head  <= h;
        cfg_req_data  <= {e.bar_base, 2'b00, e.dev_type, e.dev_num};
    endtask

    // one cfg beat, held until valid & ready meet on an edge
    task automatic cfg_access(input logic is_wr, input logic [31:0] addr, input tab_entry_t e);
        bit taken;
        @(posedge clk);
        drive_cfg(is_wr, addr, e);
        do begin
            @(negedge clk);
            taken = cfg_req_ready;
            @(posedge clk);
        end while (!taken);
        cfg_req_valid <= 1'b0;
        model_update(is_wr, addr, e);
    endtask

    task automatic cfg_write(input logic [`TAB_AW-1:0] idx, input tab_entry_t e);
        cfg_access(1'b1, entry_addr(idx), e);
    endtask

    task automatic cfg_read(input logic [`TAB_AW-1:0] idx);
        cfg_access(1'b0, entry_addr(idx), rand_entry());   // data ignored on reads
    endtask

    task automatic drive_head(input logic [7:0] dst);
        fwd_head_t h;
        h         = '0;
        h.dst_dev = dst;
        upper_valid <= 1'b1;
        upper_ready <= 1'b1;
        upper_last  <= 1'b1;
        upper_head  <= h;
    endtask

    // packet of n beats, odd beats stall one cycle when asked
    task automatic send_packet(input logic [7:0] dst, input int beats, input bit stall);
        fwd_head_t   h;
        logic [31:0] r;
        bit          hold;
        for (int i = 0; i < beats; i++) begin
            r          = $random(seed);
            hold       = stall && (i % 2 == 1);
            h          = '0;
            h.dst_dev  = (i == 0) ? dst : r[7:0];      // junk dst after the head
            h.src_dev  = r[15:8];
            h.byte_len = 16'(beats * 8);
            @(posedge clk);
            upper_valid <= 1'b1;
            upper_last  <= (i == beats - 1);
            upper_head  <= h;
            upper_ready <= !hold;
            if (hold) begin
                @(posedge clk);
                upper_ready <= 1'b1;
            end
        end
        @(posedge clk);                                // last beat moves here
        upper_valid <= 1'b0;
        upper_ready <= 1'b0;
        upper_last  <= 1'b0;
    endtask

    task automatic check_entry(input logic [`TAB_AW-1:0] idx);
        check("route.bar_base", 128'(route.bar_base), 128'(model_mem[idx].bar_base));
        check("route.dev_type", 128'(route.dev_type), 128'(model_mem[idx].dev_type));
        check("route.dev_num", 128'(route.dev_num), 128'(model_mem[idx].dev_num));
    endtask

    // wait for a result, compare with the model, then consume it
    task automatic wait_route(input logic [`TAB_AW-1:0] idx);
        @(negedge clk);
        while (!route_valid) @(negedge clk);
        check("route.hit", 128'(route.hit), 128'(model_vld[idx]));
        if (model_vld[idx]) check_entry(idx);
        @(posedge clk);
        is_ready <= 1'b1;
        @(posedge clk);
        is_ready <= 1'b0;                              // taken on this edge
        @(negedge clk);
        check("route_valid", 128'(route_valid), 128'd0);
    endtask

    // **********************************************************************
    // directed tests
    // **********************************************************************
    task automatic test_reset_miss();
        @(negedge clk);
        check("route_valid", 128'(route_valid), 128'd0);
        check("cfg_req_ready", 128'(cfg_req_ready), 128'd1);
        send_packet(8'h2A, 1, 1'b0);
        @(negedge clk);
        check("route_valid", 128'(route_valid), 128'd1);   // one clock after handshake
        wait_route(4'hA);
    endtask

    task automatic test_fill_all();
        for (int i = 0; i < DEPTH; i++) cfg_write(4'(i), rand_entry());
        for (int i = 0; i < DEPTH; i++) begin
            send_packet({4'(i + 3), 4'(i)}, 1, 1'b0);  // upper dst bits don't index
            wait_route(4'(i));
        end
    endtask

    task automatic test_no_write();
        cfg_read(4'd3);
        cfg_access(1'b1, entry_addr(4'd5) ^ 32'h0004_0000, rand_entry());  // off window
        send_packet(8'h13, 1, 1'b0);
        wait_route(4'd3);
        send_packet(8'h05, 1, 1'b0);
        wait_route(4'd5);
    endtask

    task automatic test_multi_beat();
        int base;
        base = results;
        @(posedge clk);
        is_ready <= 1'b1;                              // downstream always ready here
        send_packet(8'h06, 4, 1'b1);
        repeat (2) begin
            @(negedge clk);
            check("route_valid", 128'(route_valid), 128'd0);
        end
        check("route_count", 128'(results - base), 128'd1);
        send_packet(8'h07, 1, 1'b0);
        @(negedge clk);
        check("route_valid", 128'(route_valid), 128'd1);
        @(negedge clk);
        check("route_count", 128'(results - base), 128'd2);
        check("route_valid", 128'(route_valid), 128'd0);
        @(posedge clk);
        is_ready <= 1'b0;
    endtask

    task automatic test_cfg_collision();
        tab_entry_t e;
        e = rand_entry();
        // offered on the head beat only, then pulled back
        @(posedge clk);
        drive_head(8'h04);
        drive_cfg(1'b1, entry_addr(4'd9), e);
        @(negedge clk);
        check("cfg_req_ready", 128'(cfg_req_ready), 128'd0);
        @(posedge clk);
        upper_valid   <= 1'b0;
        cfg_req_valid <= 1'b0;
        wait_route(4'd4);
        send_packet(8'h09, 1, 1'b0);
        wait_route(4'd9);                              // still the old entry
        // same collision, request held this time
        @(posedge clk);
        drive_head(8'h04);
        drive_cfg(1'b1, entry_addr(4'd9), e);
        @(negedge clk);
        check("cfg_req_ready", 128'(cfg_req_ready), 128'd0);
        @(posedge clk);
        upper_valid <= 1'b0;
        @(negedge clk);
        check("cfg_req_ready", 128'(cfg_req_ready), 128'd1);
        @(posedge clk);
        cfg_req_valid <= 1'b0;                         // write lands on this edge
        model_update(1'b1, entry_addr(4'd9), e);
        wait_route(4'd4);
        send_packet(8'h09, 1, 1'b0);
        wait_route(4'd9);
    endtask

    task automatic test_hold();
        tab_entry_t e;
        route_t     exp_route;
        e          = model_mem[7];
        e.bar_base = ~e.bar_base;                      // every field differs from the old word
        e.dev_type = ~e.dev_type;
        e.dev_num  = ~e.dev_num;
        cfg_write(4'd7, e);
        exp_route = '{hit:      model_vld[7],
                      bar_base: model_mem[7].bar_base,
                      dev_type: model_mem[7].dev_type,
                      dev_num:  model_mem[7].dev_num};
        send_packet(8'h77, 1, 1'b0);
        repeat (6) begin
            @(negedge clk);
            check("route_valid", 128'(route_valid), 128'd1);
            check("route", 128'(route), 128'(exp_route));
        end
        wait_route(4'd7);
    endtask

    // **********************************************************************
    // main sequence
    // **********************************************************************
    initial begin
        rst_n         = 1'b0;
        cfg_req_valid = 1'b0;
        cfg_req_last  = 1'b0;
        cfg_req_data  = '0;
        cfg_req_head  = '0;
        upper_valid   = 1'b0;
        upper_last    = 1'b0;
        upper_head    = '0;
        upper_ready   = 1'b0;
        is_ready      = 1'b0;
        model_vld     = '0;                            // table empty after reset
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_miss();
        test_fill_all();
        test_no_write();
        test_multi_beat();
        test_cfg_collision();
        test_hold();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/p2p_fwd_pkg.sv
rtl/p2p_cfg_pkg.sv
rtl/cfg_decode.sv
rtl/dev_table_sram.sv
rtl/fwd_ctrl.sv
rtl/dev2addr_top.sv
tests/tb_dev2addr.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0 --timing
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_dev2addr
RTL_TOP   ?= dev2addr_top
FILELIST  ?= all.f
PASS_MSG  := Verification passed

SIM     := obj_dir/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh tests/*.sv)

.PHONY: all run lint clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# pass only when the pass message shows up in the output
run: $(SIM)
	@out=$$(./$(SIM) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
